/* common/noc_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// single-flit packets only; the destination port and VC ride in the flit.
// field widths derive from num_ports and num_vcs, which are powers of two.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package noc_pkg;

    localparam int num_ports = 4;
    localparam int num_vcs = 2;

    // downstream slots per VC, also the reset value of every output credit counter.
    localparam int buffer_size = 4;

    // input FIFO depth, also the credits an upstream sender starts with.
    localparam int fifo_depth = 4;

    localparam int port_w = $clog2(num_ports);
    localparam int vc_w = $clog2(num_vcs);
    localparam int cnt_w = $clog2(buffer_size + 1);
    localparam int payload_w = 29;
    localparam int flit_w = port_w + vc_w + payload_w;

    // flit layout is {dest, vc, payload} from the top bit down.
    localparam int vc_lsb = payload_w;
    localparam int dest_lsb = vc_lsb + vc_w;

    localparam int fifo_ptr_w = $clog2(fifo_depth);
    localparam int fifo_cnt_w = $clog2(fifo_depth + 1);

    typedef logic [flit_w-1:0] flit_t;
    typedef logic [port_w-1:0] port_t;
    typedef logic [vc_w-1:0] vc_t;
    typedef logic [cnt_w-1:0] cnt_t;

    localparam port_t last_port = port_t'(num_ports - 1);
    localparam cnt_t cnt_full = cnt_t'(buffer_size);
    localparam logic [fifo_ptr_w-1:0] fifo_last = fifo_ptr_w'(fifo_depth - 1);

endpackage

/* source/input_fifo.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// no full flag; the upstream sender must honour its credits.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module input_fifo (
    input  logic           clk,
    input  logic           n_rst,
    input  logic           wr_valid,
    input  noc_pkg::flit_t wr_flit,
    input  logic           pop,
    output logic           head_valid,
    output noc_pkg::flit_t head_flit,
    output logic           credit
);
    noc_pkg::flit_t mem [noc_pkg::fifo_depth];
    logic [noc_pkg::fifo_ptr_w-1:0] rd_ptr;
    logic [noc_pkg::fifo_ptr_w-1:0] wr_ptr;
    logic [noc_pkg::fifo_cnt_w-1:0] count;
    logic do_pop;

    assign head_valid = (count != '0);
    assign head_flit = mem[rd_ptr];
    assign do_pop = pop && head_valid;

    // the credit goes back upstream in the same cycle the flit leaves.
    assign credit = do_pop;

    always_ff @(posedge clk) begin
        if (wr_valid) begin
            mem[wr_ptr] <= wr_flit;
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (wr_valid) begin
                wr_ptr <= (wr_ptr == noc_pkg::fifo_last) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == noc_pkg::fifo_last) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_valid, do_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* source/switch_allocator.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one round-robin arbiter per output, combinational from head and credit state.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module switch_allocator (
    input  logic                                                   clk,
    input  logic                                                   n_rst,
    input  logic [noc_pkg::num_ports-1:0]                          head_valid,
    input  noc_pkg::flit_t [noc_pkg::num_ports-1:0]                head_flit,
    input  logic [noc_pkg::num_ports-1:0][noc_pkg::num_vcs-1:0]    credit_ok,
    output logic [noc_pkg::num_ports-1:0]                          grant,
    output noc_pkg::port_t [noc_pkg::num_ports-1:0]                sel,
    output logic [noc_pkg::num_ports-1:0]                          sel_valid
);
    // req[o][i] means input i wants output o and that output's VC has room.
    logic [noc_pkg::num_ports-1:0][noc_pkg::num_ports-1:0] req;
    noc_pkg::port_t [noc_pkg::num_ports-1:0] rr_ptr;
    noc_pkg::port_t [noc_pkg::num_ports-1:0] head_dest;
    noc_pkg::vc_t [noc_pkg::num_ports-1:0] head_vc;

    always_comb begin
        for (int i = 0; i < noc_pkg::num_ports; i++) begin
            head_dest[i] = head_flit[i][noc_pkg::dest_lsb +: noc_pkg::port_w];
            head_vc[i] = head_flit[i][noc_pkg::vc_lsb +: noc_pkg::vc_w];
        end
    end

    always_comb begin
        for (int o = 0; o < noc_pkg::num_ports; o++) begin
            for (int i = 0; i < noc_pkg::num_ports; i++) begin
                req[o][i] = head_valid[i]
                    && (head_dest[i] == noc_pkg::port_t'(o))
                    && credit_ok[o][head_vc[i]];
            end
        end
    end

    // each input has a single destination, so at most one output grants it.
    always_comb begin
        int idx;
        grant = '0;
        sel = '0;
        sel_valid = '0;
        for (int o = 0; o < noc_pkg::num_ports; o++) begin
            for (int k = 0; k < noc_pkg::num_ports; k++) begin
                idx = (int'(rr_ptr[o]) + k) % noc_pkg::num_ports;
                if (!sel_valid[o] && req[o][idx]) begin
                    sel_valid[o] = 1'b1;
                    sel[o] = noc_pkg::port_t'(idx);
                    grant[idx] = 1'b1;
                end
            end
        end
    end

    // the pointer moves just past the winner so it has lowest priority next time.
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            rr_ptr <= '0;
        end else begin
            for (int o = 0; o < noc_pkg::num_ports; o++) begin
                if (sel_valid[o]) begin
                    if (sel[o] == noc_pkg::last_port) begin
                        rr_ptr[o] <= '0;
                    end else begin
                        rr_ptr[o] <= sel[o] + 1'b1;
                    end
                end
            end
        end
    end

endmodule

/* crossbar/crossbar.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// outputs are registered; one credit per flit, returns saturate at buffer_size.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module crossbar (
    input  logic                                                   clk,
    input  logic                                                   n_rst,
    input  noc_pkg::flit_t [noc_pkg::num_ports-1:0]                in_flit,
    input  noc_pkg::port_t [noc_pkg::num_ports-1:0]                sel,
    input  logic [noc_pkg::num_ports-1:0]                          sel_valid,
    input  logic [noc_pkg::num_ports-1:0][noc_pkg::num_vcs-1:0]    credit_return,
    output logic [noc_pkg::num_ports-1:0][noc_pkg::num_vcs-1:0]    credit_ok,
    output logic [noc_pkg::num_ports-1:0]                          out_valid,
    output noc_pkg::flit_t [noc_pkg::num_ports-1:0]                out_flit,
    output noc_pkg::vc_t [noc_pkg::num_ports-1:0]                  out_vc
);
    noc_pkg::flit_t [noc_pkg::num_ports-1:0] sel_flit;
    noc_pkg::vc_t [noc_pkg::num_ports-1:0] sel_vc;
    noc_pkg::cnt_t [noc_pkg::num_ports-1:0][noc_pkg::num_vcs-1:0] credit_cnt;
    noc_pkg::cnt_t [noc_pkg::num_ports-1:0][noc_pkg::num_vcs-1:0] credit_cnt_next;

    always_comb begin
        for (int o = 0; o < noc_pkg::num_ports; o++) begin
            sel_flit[o] = in_flit[sel[o]];
            sel_vc[o] = sel_flit[o][noc_pkg::vc_lsb +: noc_pkg::vc_w];
        end
    end

    // the flit register only loads on a grant; out_valid qualifies it.
    always_ff @(posedge clk) begin
        for (int o = 0; o < noc_pkg::num_ports; o++) begin
            if (sel_valid[o]) begin
                out_flit[o] <= sel_flit[o];
                out_vc[o] <= sel_vc[o];
            end
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            out_valid <= '0;
        end else begin
            out_valid <= sel_valid;
        end
    end

    // a send and a return in the same cycle cancel out.
    always_comb begin
        logic dec;
        logic inc;
        for (int o = 0; o < noc_pkg::num_ports; o++) begin
            for (int v = 0; v < noc_pkg::num_vcs; v++) begin
                dec = sel_valid[o] && (sel_vc[o] == noc_pkg::vc_t'(v));
                inc = credit_return[o][v];
                credit_cnt_next[o][v] = credit_cnt[o][v];
                if (inc && !dec && credit_cnt[o][v] != noc_pkg::cnt_full) begin
                    credit_cnt_next[o][v] = credit_cnt[o][v] + 1'b1;
                end else if (dec && !inc && credit_cnt[o][v] != '0) begin
                    credit_cnt_next[o][v] = credit_cnt[o][v] - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            for (int o = 0; o < noc_pkg::num_ports; o++) begin
                for (int v = 0; v < noc_pkg::num_vcs; v++) begin
                    credit_cnt[o][v] <= noc_pkg::cnt_full;
                end
            end
        end else begin
            credit_cnt <= credit_cnt_next;
        end
    end

    // the allocator sees the registered count, so a send blocks the next grant at once.
    always_comb begin
        for (int o = 0; o < noc_pkg::num_ports; o++) begin
            for (int v = 0; v < noc_pkg::num_vcs; v++) begin
                credit_ok[o][v] = (credit_cnt[o][v] != '0);
            end
        end
    end

endmodule

/* source/noc_router.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// senders start with fifo_depth credits per port; latency is two cycles or more.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module noc_router (
    input  logic                                                   clk,
    input  logic                                                   n_rst,
    input  logic [noc_pkg::num_ports-1:0]                          in_valid,
    input  noc_pkg::flit_t [noc_pkg::num_ports-1:0]                in_flit,
    output logic [noc_pkg::num_ports-1:0]                          in_credit,
    output logic [noc_pkg::num_ports-1:0]                          out_valid,
    output noc_pkg::flit_t [noc_pkg::num_ports-1:0]                out_flit,
    output noc_pkg::vc_t [noc_pkg::num_ports-1:0]                  out_vc,
    input  logic [noc_pkg::num_ports-1:0][noc_pkg::num_vcs-1:0]    credit_return
);
    logic [noc_pkg::num_ports-1:0] head_valid;
    noc_pkg::flit_t [noc_pkg::num_ports-1:0] head_flit;
    logic [noc_pkg::num_ports-1:0] grant;
    noc_pkg::port_t [noc_pkg::num_ports-1:0] sel;
    logic [noc_pkg::num_ports-1:0] sel_valid;
    logic [noc_pkg::num_ports-1:0][noc_pkg::num_vcs-1:0] credit_ok;

    for (genvar p = 0; p < noc_pkg::num_ports; p++) begin : g_in
        input_fifo fifo_i (
            .clk        (clk),
            .n_rst      (n_rst),
            .wr_valid   (in_valid[p]),
            .wr_flit    (in_flit[p]),
            .pop        (grant[p]),
            .head_valid (head_valid[p]),
            .head_flit  (head_flit[p]),
            .credit     (in_credit[p])
        );
    end

    switch_allocator alloc_i (
        .clk        (clk),
        .n_rst      (n_rst),
        .head_valid (head_valid),
        .head_flit  (head_flit),
        .credit_ok  (credit_ok),
        .grant      (grant),
        .sel        (sel),
        .sel_valid  (sel_valid)
    );

    crossbar xbar_i (
        .clk           (clk),
        .n_rst         (n_rst),
        .in_flit       (head_flit),
        .sel           (sel),
        .sel_valid     (sel_valid),
        .credit_return (credit_return),
        .credit_ok     (credit_ok),
        .out_valid     (out_valid),
        .out_flit      (out_flit),
        .out_vc        (out_vc)
    );

endmodule

/* bench/tb_util.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// included inside router_tb; uses its checks, errors and rng_state.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef TB_UTIL_SVH
`define TB_UTIL_SVH

// compares an expected and an actual value and counts the result.
task automatic check(input string name, input logic [31:0] expected,
                     input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
        errors++;
        $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
    end
endtask

task automatic report_error(input string msg);
    errors++;
    $display("ERROR at %0t ns: %s", $time, msg);
endtask

function automatic logic [31:0] xorshift(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

function automatic logic [31:0] next_rand();
    rng_state = xorshift(rng_state);
    return rng_state;
endfunction

// a value from 0 to n-1.
function automatic int rand_below(input int n);
    logic [31:0] r;
    r = next_rand();
    return int'(r % 32'(n));
endfunction

`endif

/* bench/router_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// the top payload bits carry the source port, so each output flit maps to its sender.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module router_tb;

    typedef struct {
        string name;
        int src;
        int dest;
        int vc;
        logic [noc_pkg::payload_w-1:0] payload;
        bit hold;
    } entry_t;

    logic clk = 1'b0;
    logic n_rst = 1'b0;
    logic [noc_pkg::num_ports-1:0] in_valid = '0;
    noc_pkg::flit_t [noc_pkg::num_ports-1:0] in_flit = '0;
    logic [noc_pkg::num_ports-1:0][noc_pkg::num_vcs-1:0] credit_return = '0;
    logic [noc_pkg::num_ports-1:0] in_credit;
    logic [noc_pkg::num_ports-1:0] out_valid;
    noc_pkg::flit_t [noc_pkg::num_ports-1:0] out_flit;
    noc_pkg::vc_t [noc_pkg::num_ports-1:0] out_vc;

    int checks = 0;
    int errors = 0;
    int tests = 0;
    int cycle = 0;
    logic [31:0] rng_state = 32'h0384_e026;
    string cur_name = "reset_state";
    bit hold_returns = 1'b0;
    bit random_delays = 1'b0;
    entry_t tbl[$];
    int pend [noc_pkg::num_ports][$];
    noc_pkg::flit_t exp_q [noc_pkg::num_ports*noc_pkg::num_ports][$];
    noc_pkg::flit_t fifo_model [noc_pkg::num_ports][$];
    int ret_due [noc_pkg::num_ports*noc_pkg::num_vcs][$];
    int up_credit [noc_pkg::num_ports] = '{default: noc_pkg::fifo_depth};
    int sent_cnt [noc_pkg::num_ports] = '{default: 0};
    int credit_seen [noc_pkg::num_ports] = '{default: 0};
    int wait_cnt [noc_pkg::num_ports] = '{default: 0};
    int outstanding [noc_pkg::num_ports][noc_pkg::num_vcs] = '{default: 0};
    int rcv_cnt [noc_pkg::num_ports][noc_pkg::num_vcs] = '{default: 0};
    int want_cnt [noc_pkg::num_ports][noc_pkg::num_vcs] = '{default: 0};

    `include "tb_util.svh"

    noc_router dut_i (
        .clk           (clk),
        .n_rst         (n_rst),
        .in_valid      (in_valid),
        .in_flit       (in_flit),
        .in_credit     (in_credit),
        .out_valid     (out_valid),
        .out_flit      (out_flit),
        .out_vc        (out_vc),
        .credit_return (credit_return)
    );

    always #4 clk = ~clk;

    // flit layout is {dest, vc, payload} from the top bit down.
    function automatic noc_pkg::flit_t pack_flit(input int i);
        return {noc_pkg::port_t'(tbl[i].dest), noc_pkg::vc_t'(tbl[i].vc), tbl[i].payload};
    endfunction

    function automatic void add_entry(input string name, input int src, input int dest,
                                      input int vc, input logic [31:0] bits, input bit hold);
        entry_t e;
        e.name = name;
        e.src = src;
        e.dest = dest;
        e.vc = vc;
        e.payload = bits[noc_pkg::payload_w-1:0];
        e.payload[noc_pkg::payload_w-1 -: noc_pkg::port_w] = noc_pkg::port_t'(src);
        e.hold = hold;
        tbl.push_back(e);
    endfunction

    function automatic void build_table();
        int src;
        int dest;
        int vc;
        for (int s = 0; s < noc_pkg::num_ports; s++) begin
            for (int d = 0; d < noc_pkg::num_ports; d++) begin
                add_entry("routing", s, d, (s + d) % noc_pkg::num_vcs,
                          32'h0100_0000 + 32'(s * 16 + d), 1'b0);
            end
        end
        // six flits per output and VC, two more than the downstream buffer holds.
        for (int k = 0; k < 6; k++) begin
            add_entry("credit_limit", k % 2, 2, 0, 32'h0200_0000 + 32'(k), 1'b1);
            add_entry("credit_limit", 2 + k % 2, 3, 1, 32'h0300_0000 + 32'(k), 1'b1);
        end
        for (int k = 0; k < 6; k++) begin
            for (int s = 0; s < noc_pkg::num_ports; s++) begin
                add_entry("contention", s, 1, 0, 32'h0400_0000 + 32'(k), 1'b0);
            end
        end
        for (int k = 0; k < 40; k++) begin
            src = rand_below(noc_pkg::num_ports);
            dest = rand_below(noc_pkg::num_ports);
            vc = rand_below(noc_pkg::num_vcs);
            add_entry("random_mix", src, dest, vc, next_rand(), 1'b0);
        end
    endfunction

    function automatic int held_limit(input int o, input int v);
        return (want_cnt[o][v] < noc_pkg::buffer_size) ? want_cnt[o][v] : noc_pkg::buffer_size;
    endfunction

    function automatic bit limit_reached();
        for (int o = 0; o < noc_pkg::num_ports; o++) begin
            for (int v = 0; v < noc_pkg::num_vcs; v++) begin
                if (rcv_cnt[o][v] < held_limit(o, v)) begin
                    return 1'b0;
                end
            end
        end
        return 1'b1;
    endfunction

    // drained means every flit delivered and every downstream credit handed back.
    function automatic bit all_drained();
        for (int p = 0; p < noc_pkg::num_ports; p++) begin
            if (pend[p].size() != 0 || fifo_model[p].size() != 0) begin
                return 1'b0;
            end
        end
        foreach (exp_q[k]) begin
            if (exp_q[k].size() != 0) begin
                return 1'b0;
            end
        end
        foreach (ret_due[k]) begin
            if (ret_due[k].size() != 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    function automatic bit same_route(input noc_pkg::flit_t a, input noc_pkg::flit_t b);
        return a[noc_pkg::flit_w-1:noc_pkg::vc_lsb] == b[noc_pkg::flit_w-1:noc_pkg::vc_lsb];
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic report_test(input int errs_before);
        tests++;
        $display("test %-12s done with %0d errors", cur_name, errors - errs_before);
    endtask

    task automatic receive_flit(input int o);
        int src;
        int v;
        noc_pkg::flit_t want;
        src = int'(out_flit[o][noc_pkg::payload_w-1 -: noc_pkg::port_w]);
        v = int'(out_vc[o]);
        if (exp_q[src * noc_pkg::num_ports + o].size() == 0) begin
            report_error($sformatf("%s: unexpected flit %h from port %0d on output %0d",
                                   cur_name, out_flit[o], src, o));
        end else begin
            want = exp_q[src * noc_pkg::num_ports + o].pop_front();
            check({cur_name, " flit"}, want, out_flit[o]);
            check({cur_name, " vc"}, 32'(want[noc_pkg::vc_lsb]), 32'(out_vc[o]));
        end
        rcv_cnt[o][v]++;
        outstanding[o][v]++;
        if (outstanding[o][v] > noc_pkg::buffer_size) begin
            report_error($sformatf("%s: output %0d VC %0d holds %0d unreturned flits",
                                   cur_name, o, v, outstanding[o][v]));
        end
        ret_due[o * noc_pkg::num_vcs + v].push_back(cycle + (random_delays ? 1 + rand_below(6) : 2));
    endtask

    // upstream sender, limited by its credits.
    always @(posedge clk) begin
        int i;
        for (int p = 0; p < noc_pkg::num_ports; p++) begin
            if (n_rst && pend[p].size() > 0 && up_credit[p] > 0) begin
                i = pend[p].pop_front();
                in_valid[p] <= 1'b1;
                in_flit[p] <= pack_flit(i);
                up_credit[p]--;
                sent_cnt[p]++;
                exp_q[tbl[i].src * noc_pkg::num_ports + tbl[i].dest].push_back(pack_flit(i));
            end else begin
                in_valid[p] <= 1'b0;
            end
        end
    end

    // downstream neighbour, one return per output and VC per cycle.
    always @(posedge clk) begin
        int k;
        for (int o = 0; o < noc_pkg::num_ports; o++) begin
            for (int v = 0; v < noc_pkg::num_vcs; v++) begin
                k = o * noc_pkg::num_vcs + v;
                if (!hold_returns && ret_due[k].size() > 0 && ret_due[k][0] <= cycle) begin
                    void'(ret_due[k].pop_front());
                    credit_return[o][v] <= 1'b1;
                    outstanding[o][v]--;
                end else begin
                    credit_return[o][v] <= 1'b0;
                end
            end
        end
        cycle++;
    end

    // the FIFO model is updated at the falling edge, after pops and before writes land.
    always @(negedge clk) begin
        if (n_rst) begin
            for (int s = 0; s < noc_pkg::num_ports; s++) begin
                if (fifo_model[s].size() == 0 || in_credit[s]) begin
                    wait_cnt[s] = 0;
                end else begin
                    for (int g = 0; g < noc_pkg::num_ports; g++) begin
                        if (in_credit[g] && fifo_model[g].size() > 0
                                && same_route(fifo_model[g][0], fifo_model[s][0])) begin
                            wait_cnt[s]++;
                        end
                    end
                    if (wait_cnt[s] > noc_pkg::num_ports - 1) begin
                        report_error($sformatf("%s: port %0d passed over %0d times in a row",
                                               cur_name, s, wait_cnt[s]));
                    end
                end
            end
            for (int p = 0; p < noc_pkg::num_ports; p++) begin
                if (in_credit[p]) begin
                    credit_seen[p]++;
                    up_credit[p]++;
                    if (fifo_model[p].size() == 0) begin
                        report_error($sformatf("credit pulse on port %0d with no flit queued", p));
                    end else begin
                        void'(fifo_model[p].pop_front());
                    end
                    if (up_credit[p] > noc_pkg::fifo_depth) begin
                        report_error($sformatf("port %0d returned more credits than flits", p));
                    end
                end
                if (in_valid[p]) begin
                    fifo_model[p].push_back(in_flit[p]);
                end
            end
            for (int o = 0; o < noc_pkg::num_ports; o++) begin
                if (out_valid[o]) begin
                    receive_flit(o);
                end
            end
        end
    end

    task automatic run_test(input int first, input int last);
        int errs_before;
        errs_before = errors;
        cur_name = tbl[first].name;
        random_delays = (cur_name == "random_mix");
        hold_returns = tbl[first].hold;
        for (int o = 0; o < noc_pkg::num_ports; o++) begin
            for (int v = 0; v < noc_pkg::num_vcs; v++) begin
                want_cnt[o][v] = 0;
                rcv_cnt[o][v] = 0;
            end
        end
        for (int i = first; i <= last; i++) begin
            pend[tbl[i].src].push_back(i);
            want_cnt[tbl[i].dest][tbl[i].vc]++;
        end
        if (hold_returns) begin
            while (!limit_reached()) begin
                next_cycle();
            end
            // give any flit beyond the credit limit time to show up.
            repeat (10) next_cycle();
            for (int o = 0; o < noc_pkg::num_ports; o++) begin
                for (int v = 0; v < noc_pkg::num_vcs; v++) begin
                    check($sformatf("%s out %0d vc %0d count", cur_name, o, v),
                          32'(held_limit(o, v)), 32'(rcv_cnt[o][v]));
                end
            end
            hold_returns = 1'b0;
        end
        while (!all_drained()) begin
            next_cycle();
        end
        for (int p = 0; p < noc_pkg::num_ports; p++) begin
            check($sformatf("%s port %0d in_credit count", cur_name, p),
                  32'(sent_cnt[p]), 32'(credit_seen[p]));
        end
        report_test(errs_before);
    endtask

    initial begin
        int first;
        int last;
        build_table();
        repeat (10) begin
            next_cycle();
            check("reset_state out_valid", 32'h0, 32'(out_valid));
            check("reset_state in_credit", 32'h0, 32'(in_credit));
        end
        @(posedge clk);
        n_rst <= 1'b1;
        repeat (3) begin
            next_cycle();
            check("reset_state out_valid", 32'h0, 32'(out_valid));
            check("reset_state in_credit", 32'h0, 32'(in_credit));
        end
        report_test(0);
        first = 0;
        while (first < tbl.size()) begin
            last = first;
            while (last + 1 < tbl.size() && tbl[last + 1].name == tbl[first].name) begin
                last++;
            end
            run_test(first, last);
            first = last + 1;
        end
        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // budget of twenty cycles per table entry plus a margin.
    initial begin
        @(posedge n_rst);
        repeat (tbl.size() * 20 + 500) @(posedge clk);
        $display("run timed out in test %s with flits still in flight", cur_name);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* files.f */
+incdir+bench
common/noc_pkg.sv
source/input_fifo.sv
source/switch_allocator.sv
crossbar/crossbar.sv
source/noc_router.sv
bench/router_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds router_tb with Verilator, runs it into sim.log and looks for the fail message.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing -Wno-fatal -f files.f --top-module router_tb \
    > build.log 2>&1 \
    && ./obj_dir/Vrouter_tb > sim.log 2>&1 \
    || echo "Simulation failed" >> sim.log

cat sim.log

grep -q "Simulation failed" sim.log \
    && echo "result: FAIL (see sim.log and build.log)" \
    && exit 1

echo "result: PASS"
exit 0
